// File: Bender.yml
package:
  name: rename_dispatch

sources:
  - files:
      - src/isa_pkg.sv
      - src/ooo_pkg.sv
      - src/decoder.sv
      - src/map_table.sv
      - src/free_list.sv
      - src/dispatch_stage.sv
      - src/dispatch_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/dispatch_tb.sv

// File: project.f
src/isa_pkg.sv
src/ooo_pkg.sv
src/decoder.sv
src/map_table.sv
src/free_list.sv
src/dispatch_stage.sv
src/dispatch_top.sv
test/tb_clock.sv
test/dispatch_tb.sv

// File: src/decoder.sv
`timescale 1ns/10ps
module decoder (
	input  ooo_pkg::fetch_packet_t fetch,
	output ooo_pkg::decode_t       dec
);
	import isa_pkg::*;
	import ooo_pkg::*;

	inst_t   inst;
	opcode_e opcode;
	logic    bad; // not in the supported RV32IM subset

	assign inst = fetch.inst;
	assign opcode = opcode_e'(inst.r.opcode);

	// register and immediate forms share the funct3 map
	function automatic alu_op_e alu_op(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000: alu_op = alt ? ALU_SUB : ALU_ADD;
			3'b001: alu_op = ALU_SLL;
			3'b010: alu_op = ALU_SLT;
			3'b011: alu_op = ALU_SLTU;
			3'b100: alu_op = ALU_XOR;
			3'b101: alu_op = alt ? ALU_SRA : ALU_SRL;
			3'b110: alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
	endfunction

	always_comb begin
		dec = NOOP_DECODE;
		bad = 1'b0;
		if (fetch.valid) begin
			case (opcode)
				OP_LUI, OP_AUIPC: begin
					dec.op_sel.alu = ALU_ADD;
					dec.dest = inst.u.rd;
					dec.opa_select = (opcode == OP_LUI) ? OPA_IS_ZERO : OPA_IS_PC;
					dec.opb_select = OPB_IS_U_IMM;
				end
				OP_JAL: begin
					dec.fu_sel = BRANCH;
					dec.op_sel.br = UNCOND;
					dec.dest = inst.j.rd;
					dec.opa_select = OPA_IS_PC;
					dec.opb_select = OPB_IS_J_IMM;
				end
				OP_JALR: begin
					dec.fu_sel = BRANCH;
					dec.op_sel.br = UNCOND;
					dec.dest = inst.i.rd;
					dec.rs1 = inst.i.rs1;
					dec.opb_select = OPB_IS_I_IMM;
					bad = inst.i.funct3 != 3'b000;
				end
				OP_BRANCH: begin
					dec.fu_sel = BRANCH;
					dec.rs1 = inst.b.rs1;
					dec.rs2 = inst.b.rs2;
					dec.opa_select = OPA_IS_PC;
					dec.opb_select = OPB_IS_B_IMM; // no destination
					case (inst.b.funct3)
						3'b000: dec.op_sel.br = BEQ;
						3'b001: dec.op_sel.br = BNE;
						3'b100: dec.op_sel.br = BLT;
						3'b101: dec.op_sel.br = BGE;
						3'b110: dec.op_sel.br = BLTU;
						3'b111: dec.op_sel.br = BGEU;
						default: bad = 1'b1;
					endcase
				end
				OP_LOAD: begin
					dec.fu_sel = LS_1;
					dec.dest = inst.i.rd;
					dec.rs1 = inst.i.rs1;
					dec.opb_select = OPB_IS_I_IMM;
					case (inst.i.funct3)
						3'b000: dec.op_sel.ls = LS_LB;
						3'b001: dec.op_sel.ls = LS_LH;
						3'b010: dec.op_sel.ls = LS_LW;
						3'b100: dec.op_sel.ls = LS_LBU;
						3'b101: dec.op_sel.ls = LS_LHU;
						default: bad = 1'b1;
					endcase
				end
				OP_STORE: begin
					dec.fu_sel = LS_1;
					dec.rs1 = inst.s.rs1;
					dec.rs2 = inst.s.rs2;
					dec.opb_select = OPB_IS_S_IMM;
					case (inst.s.funct3)
						3'b000: dec.op_sel.ls = LS_SB;
						3'b001: dec.op_sel.ls = LS_SH;
						3'b010: dec.op_sel.ls = LS_SW;
						default: bad = 1'b1;
					endcase
				end
				OP_IMM: begin
					dec.dest = inst.i.rd;
					dec.rs1 = inst.i.rs1;
					dec.opb_select = OPB_IS_I_IMM;
					// shift immediates keep funct7 in the upper bits
					dec.op_sel.alu = alu_op(inst.r.funct3,
						inst.r.funct3 == 3'b101 && inst.r.funct7 == F7_ALT);
					if (inst.r.funct3 == 3'b001)
						bad = inst.r.funct7 != F7_BASE;
					else if (inst.r.funct3 == 3'b101)
						bad = inst.r.funct7 != F7_BASE && inst.r.funct7 != F7_ALT;
				end
				OP_REG: begin
					dec.dest = inst.r.rd;
					dec.rs1 = inst.r.rs1;
					dec.rs2 = inst.r.rs2;
					if (inst.r.funct7 == F7_MULDIV) begin
						dec.fu_sel = MULT_1;
						dec.op_sel.mult = mult_op_e'({2'b00, inst.r.funct3[1:0]});
						bad = inst.r.funct3[2]; // div and rem have no unit
					end else begin
						dec.op_sel.alu = alu_op(inst.r.funct3, inst.r.funct7 == F7_ALT);
						bad = !(inst.r.funct7 == F7_BASE || (inst.r.funct7 == F7_ALT &&
							(inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101)));
					end
				end
				OP_SYSTEM: begin
					if (inst == WFI_INST)
						dec.halt = 1'b1;
					else
						bad = 1'b1;
				end
				default: bad = 1'b1;
			endcase
		end
		// illegal encodings travel as a flagged noop
		if (bad) begin
			dec = NOOP_DECODE;
			dec.illegal = 1'b1;
		end
	end

endmodule

// File: src/dispatch_stage.sv
`timescale 1ns/10ps
module dispatch_stage (
	input  ooo_pkg::fetch_packet_t [ooo_pkg::DISPATCH_WIDTH-1:0]  fetch,
	input  ooo_pkg::decode_t [ooo_pkg::DISPATCH_WIDTH-1:0]        dec,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    rs_stall,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    rob_stall,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0][ooo_pkg::ROB_BITS-1:0] rob_index,
	input  ooo_pkg::pr_t [ooo_pkg::DISPATCH_WIDTH-1:0]            head_pr,
	input  ooo_pkg::pr_count_t                                    free_count,
	output logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    alloc_en,
	output isa_pkg::ar_t [2*ooo_pkg::DISPATCH_WIDTH-1:0]          lookup_ar,
	input  ooo_pkg::pr_t [2*ooo_pkg::DISPATCH_WIDTH-1:0]          lookup_pr,
	input  logic [2*ooo_pkg::DISPATCH_WIDTH-1:0]                  lookup_ready,
	output logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    write_en,
	output isa_pkg::ar_t [ooo_pkg::DISPATCH_WIDTH-1:0]            write_ar,
	output ooo_pkg::pr_t [ooo_pkg::DISPATCH_WIDTH-1:0]            write_pr,
	input  ooo_pkg::pr_t [ooo_pkg::DISPATCH_WIDTH-1:0]            old_pr,
	output ooo_pkg::rs_packet_t [ooo_pkg::DISPATCH_WIDTH-1:0]     rs_out,
	output ooo_pkg::rob_packet_t [ooo_pkg::DISPATCH_WIDTH-1:0]    rob_out,
	output logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    stall
);
	import isa_pkg::*;
	import ooo_pkg::*;

	logic [DISPATCH_WIDTH-1:0] wants; // valid with a real destination
	logic [DISPATCH_WIDTH-1:0] go;
	logic                      blocked;
	int                        taken; // PRs already given to older slots
	pr_t [DISPATCH_WIDTH-1:0]  dest_pr;
	pr_t [DISPATCH_WIDTH-1:0]  rs1_pr;
	pr_t [DISPATCH_WIDTH-1:0]  rs2_pr;
	pr_t [DISPATCH_WIDTH-1:0]  prev_pr;
	logic [DISPATCH_WIDTH-1:0] rs1_ready;
	logic [DISPATCH_WIDTH-1:0] rs2_ready;

	// a stall holds this slot and everything younger
	always_comb begin
		blocked = 1'b0;
		taken = 0;
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			wants[i] = fetch[i].valid && dec[i].dest != ZERO_REG;
			blocked = blocked | rs_stall[i] | rob_stall[i] |
				(wants[i] && taken >= int'(free_count));
			stall[i] = blocked;
			go[i] = fetch[i].valid & ~blocked;
			alloc_en[i] = wants[i] & ~blocked;
			dest_pr[i] = alloc_en[i] ? head_pr[taken] : '0; // k-th allocator takes entry k
			taken = taken + int'(alloc_en[i]);
		end
	end

	always_comb begin
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			lookup_ar[2*i] = dec[i].rs1;
			lookup_ar[2*i+1] = dec[i].rs2;
			rs1_pr[i] = lookup_pr[2*i];
			rs1_ready[i] = lookup_ready[2*i];
			rs2_pr[i] = lookup_pr[2*i+1];
			rs2_ready[i] = lookup_ready[2*i+1];
			prev_pr[i] = old_pr[i];
			// ascending j leaves the nearest older writer in place
			for (int j = 0; j < i; j++) begin
				if (alloc_en[j] && dec[j].dest == dec[i].rs1) begin
					rs1_pr[i] = dest_pr[j];
					rs1_ready[i] = 1'b0;
				end
				if (alloc_en[j] && dec[j].dest == dec[i].rs2) begin
					rs2_pr[i] = dest_pr[j];
					rs2_ready[i] = 1'b0;
				end
				if (alloc_en[j] && dec[j].dest == dec[i].dest)
					prev_pr[i] = dest_pr[j];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			write_en[i] = alloc_en[i];
			write_ar[i] = dec[i].dest;
			write_pr[i] = dest_pr[i];

			rs_out[i].valid = go[i];
			rs_out[i].dec = dec[i];
			rs_out[i].pc = fetch[i].pc;
			rs_out[i].npc = fetch[i].npc;
			rs_out[i].rob_entry = rob_index[i];
			rs_out[i].dest_pr = dest_pr[i];
			rs_out[i].rs1_pr = rs1_pr[i];
			rs_out[i].rs1_ready = rs1_ready[i];
			rs_out[i].rs2_pr = rs2_pr[i];
			rs_out[i].rs2_ready = rs2_ready[i];

			rob_out[i].valid = go[i];
			rob_out[i].new_pr = dest_pr[i];
			rob_out[i].old_pr = alloc_en[i] ? prev_pr[i] : '0; // nothing to free for x0
			rob_out[i].dest_ar = dec[i].dest;
			rob_out[i].halt = dec[i].halt;
		end
	end

endmodule

// File: src/dispatch_top.sv
`timescale 1ns/10ps
module dispatch_top (
	input  logic                                                  clock,
	input  logic                                                  reset,
	input  ooo_pkg::fetch_packet_t [ooo_pkg::DISPATCH_WIDTH-1:0]  fetch,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    rs_stall,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    rob_stall,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0][ooo_pkg::ROB_BITS-1:0] rob_index,
	input  logic                                                  complete_valid,
	input  ooo_pkg::pr_t                                          complete_pr,
	input  logic                                                  retire_valid,
	input  ooo_pkg::pr_t                                          retire_pr,
	output ooo_pkg::rs_packet_t [ooo_pkg::DISPATCH_WIDTH-1:0]     rs_out,
	output ooo_pkg::rob_packet_t [ooo_pkg::DISPATCH_WIDTH-1:0]    rob_out,
	output logic [ooo_pkg::DISPATCH_WIDTH-1:0]                    stall
);
	import isa_pkg::*;
	import ooo_pkg::*;

	decode_t [DISPATCH_WIDTH-1:0] dec;
	pr_t [DISPATCH_WIDTH-1:0]     head_pr;
	pr_count_t                    free_count;
	logic [DISPATCH_WIDTH-1:0]    alloc_en;
	ar_t [2*DISPATCH_WIDTH-1:0]   lookup_ar;
	pr_t [2*DISPATCH_WIDTH-1:0]   lookup_pr;
	logic [2*DISPATCH_WIDTH-1:0]  lookup_ready;
	logic [DISPATCH_WIDTH-1:0]    write_en;
	ar_t [DISPATCH_WIDTH-1:0]     write_ar;
	pr_t [DISPATCH_WIDTH-1:0]     write_pr;
	pr_t [DISPATCH_WIDTH-1:0]     old_pr;

	decoder decode_0 (.fetch(fetch[0]), .dec(dec[0]));
	decoder decode_1 (.fetch(fetch[1]), .dec(dec[1]));
	decoder decode_2 (.fetch(fetch[2]), .dec(dec[2]));

	dispatch_stage stage (
		.fetch(fetch),
		.dec(dec),
		.rs_stall(rs_stall),
		.rob_stall(rob_stall),
		.rob_index(rob_index),
		.head_pr(head_pr),
		.free_count(free_count),
		.alloc_en(alloc_en),
		.lookup_ar(lookup_ar),
		.lookup_pr(lookup_pr),
		.lookup_ready(lookup_ready),
		.write_en(write_en),
		.write_ar(write_ar),
		.write_pr(write_pr),
		.old_pr(old_pr),
		.rs_out(rs_out),
		.rob_out(rob_out),
		.stall(stall)
	);

	map_table map (
		.clock(clock),
		.reset(reset),
		.lookup_ar(lookup_ar),
		.lookup_pr(lookup_pr),
		.lookup_ready(lookup_ready),
		.write_en(write_en),
		.write_ar(write_ar),
		.write_pr(write_pr),
		.old_pr(old_pr),
		.complete_valid(complete_valid),
		.complete_pr(complete_pr)
	);

	free_list free (
		.clock(clock),
		.reset(reset),
		.alloc_en(alloc_en),
		.head_pr(head_pr),
		.free_count(free_count),
		.retire_valid(retire_valid),
		.retire_pr(retire_pr)
	);

endmodule

// File: src/free_list.sv
`timescale 1ns/10ps
module free_list (
	input  logic                                           clock,
	input  logic                                           reset,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]             alloc_en,
	output ooo_pkg::pr_t [ooo_pkg::DISPATCH_WIDTH-1:0]     head_pr,
	output ooo_pkg::pr_count_t                             free_count,
	input  logic                                           retire_valid,
	input  ooo_pkg::pr_t                                   retire_pr
);
	import ooo_pkg::*;

	pr_t       queue [PR_COUNT];
	pr_t       head; // pointers wrap at PR_COUNT by width
	pr_t       tail;
	pr_count_t count;
	pr_count_t pops;

	always_comb begin
		pops = '0;
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			pops = pops + pr_count_t'(alloc_en[k]);
			head_pr[k] = queue[head + pr_t'(k)];
		end
	end

	assign free_count = count;

	always_ff @(posedge clock) begin
		if (reset) begin
			// slots 32..63 hold PRs 32..63, the rest is overwritten by retires
			for (int k = 0; k < PR_COUNT; k++)
				queue[k] <= pr_t'(k);
			head <= pr_t'(ARCH_REGS);
			tail <= '0;
			count <= pr_count_t'(PR_COUNT - ARCH_REGS);
		end else begin
			if (retire_valid)
				queue[tail] <= retire_pr;
			head <= head + pr_t'(pops);
			tail <= tail + pr_t'(retire_valid);
			count <= count - pops + pr_count_t'(retire_valid);
		end
	end

endmodule

// File: src/isa_pkg.sv
package isa_pkg;

	typedef logic [4:0] ar_t; // architectural register number

	localparam ar_t ZERO_REG = 5'd0;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000; // sub and arithmetic shift
	localparam logic [6:0] F7_MULDIV = 7'b0000001;
	localparam logic [31:0] WFI_INST = 32'h1050_0073;

	typedef struct packed {
		logic [6:0] funct7;
		ar_t        rs2;
		ar_t        rs1;
		logic [2:0] funct3;
		ar_t        rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		ar_t         rs1;
		logic [2:0]  funct3;
		ar_t         rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		ar_t        rs2;
		ar_t        rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		ar_t        rs2;
		ar_t        rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_type_t;

	typedef struct packed {
		logic [19:0] imm;
		ar_t         rd;
		logic [6:0]  opcode;
	} u_type_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		ar_t        rd;
		logic [6:0] opcode;
	} j_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		b_type_t b;
		u_type_t u;
		j_type_t j;
	} inst_t;

	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011,
		OP_REG    = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [1:0] {ALU_1, LS_1, MULT_1, BRANCH} fu_select_e;

	// all four op enums are 4 bits so they overlay in op_select_t
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;
	typedef enum logic [3:0] {UNCOND, BEQ, BNE, BLT, BGE, BLTU, BGEU} br_op_e;
	typedef enum logic [3:0] {
		LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU, LS_SB, LS_SH, LS_SW
	} ls_op_e;
	typedef enum logic [3:0] {MULT, MULH, MULHSU, MULHU} mult_op_e; // funct3 order

	typedef union packed {
		alu_op_e  alu;
		br_op_e   br;
		ls_op_e   ls;
		mult_op_e mult;
	} op_select_t;

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_NPC, OPA_IS_PC, OPA_IS_ZERO} opa_select_e;
	typedef enum logic [2:0] {
		OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM, OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
	} opb_select_e;

endpackage

// File: src/map_table.sv
`timescale 1ns/10ps
module map_table (
	input  logic                                              clock,
	input  logic                                              reset,
	input  isa_pkg::ar_t [2*ooo_pkg::DISPATCH_WIDTH-1:0]      lookup_ar,
	output ooo_pkg::pr_t [2*ooo_pkg::DISPATCH_WIDTH-1:0]      lookup_pr,
	output logic [2*ooo_pkg::DISPATCH_WIDTH-1:0]              lookup_ready,
	input  logic [ooo_pkg::DISPATCH_WIDTH-1:0]                write_en,
	input  isa_pkg::ar_t [ooo_pkg::DISPATCH_WIDTH-1:0]        write_ar,
	input  ooo_pkg::pr_t [ooo_pkg::DISPATCH_WIDTH-1:0]        write_pr,
	output ooo_pkg::pr_t [ooo_pkg::DISPATCH_WIDTH-1:0]        old_pr,
	input  logic                                              complete_valid,
	input  ooo_pkg::pr_t                                      complete_pr
);
	import ooo_pkg::*;

	pr_t [ARCH_REGS-1:0] map;
	logic [PR_COUNT-1:0] ready;

	// reads see the table as it stood at the start of the cycle
	always_comb begin
		for (int i = 0; i < 2*DISPATCH_WIDTH; i++) begin
			lookup_pr[i] = map[lookup_ar[i]];
			lookup_ready[i] = ready[map[lookup_ar[i]]];
		end
		for (int i = 0; i < DISPATCH_WIDTH; i++)
			old_pr[i] = map[write_ar[i]];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < ARCH_REGS; r++)
				map[r] <= pr_t'(r); // identity mapping
			ready <= '1;
		end else begin
			if (complete_valid)
				ready[complete_pr] <= 1'b1;
			// slot order, so the youngest write and any rename beat completion
			for (int i = 0; i < DISPATCH_WIDTH; i++) begin
				if (write_en[i]) begin
					map[write_ar[i]] <= write_pr[i];
					ready[write_pr[i]] <= 1'b0;
				end
			end
		end
	end

endmodule

// File: src/ooo_pkg.sv
package ooo_pkg;
	import isa_pkg::*;

	localparam int DISPATCH_WIDTH = 3; // one decoder per slot
	localparam int ARCH_REGS = 32;
	localparam int PR_COUNT = 64;
	localparam int PR_BITS = 6;
	localparam int ROB_BITS = 5;

	typedef logic [PR_BITS-1:0] pr_t;
	typedef logic [PR_BITS:0] pr_count_t; // holds 0 up to PR_COUNT

	typedef struct packed {
		logic        valid;
		inst_t       inst;
		logic [31:0] pc;
		logic [31:0] npc;
	} fetch_packet_t;

	typedef struct packed {
		fu_select_e  fu_sel;
		op_select_t  op_sel;
		opa_select_e opa_select;
		opb_select_e opb_select;
		ar_t         dest;
		ar_t         rs1;
		ar_t         rs2;
		logic        halt;
		logic        illegal;
	} decode_t;

	// add x0, x0, x0 with nothing flagged
	localparam decode_t NOOP_DECODE = '{
		fu_sel: ALU_1,
		op_sel: '0,
		opa_select: OPA_IS_RS1,
		opb_select: OPB_IS_RS2,
		dest: ZERO_REG,
		rs1: ZERO_REG,
		rs2: ZERO_REG,
		halt: 1'b0,
		illegal: 1'b0
	};

	typedef struct packed {
		logic                valid;
		decode_t             dec;
		logic [31:0]         pc;
		logic [31:0]         npc;
		logic [ROB_BITS-1:0] rob_entry;
		pr_t                 dest_pr;
		pr_t                 rs1_pr;
		logic                rs1_ready;
		pr_t                 rs2_pr;
		logic                rs2_ready;
	} rs_packet_t;

	typedef struct packed {
		logic valid;
		pr_t  new_pr;
		pr_t  old_pr; // freed when this entry retires
		ar_t  dest_ar;
		logic halt;
	} rob_packet_t;

endpackage

// File: test/dispatch_tb.sv
`timescale 1ns/10ps
module dispatch_tb;
	import isa_pkg::*;
	import ooo_pkg::*;

	logic                                    clock;
	logic                                    reset;
	fetch_packet_t [DISPATCH_WIDTH-1:0]      fetch;
	logic [DISPATCH_WIDTH-1:0]               rs_stall;
	logic [DISPATCH_WIDTH-1:0]               rob_stall;
	logic [DISPATCH_WIDTH-1:0][ROB_BITS-1:0] rob_index;
	logic                                    complete_valid;
	pr_t                                     complete_pr;
	logic                                    retire_valid;
	pr_t                                     retire_pr;
	rs_packet_t [DISPATCH_WIDTH-1:0]         rs_out;
	rob_packet_t [DISPATCH_WIDTH-1:0]        rob_out;
	logic [DISPATCH_WIDTH-1:0]               stall;

	// model of the rename state
	pr_t  m_map [ARCH_REGS];
	logic m_ready [PR_COUNT];
	pr_t  free_q [$];
	pr_t  busy_q [$]; // allocated, not yet completed
	pr_t  rob_q [$];  // old PRs waiting to retire

	rs_packet_t [DISPATCH_WIDTH-1:0]  exp_rs;
	rob_packet_t [DISPATCH_WIDTH-1:0] exp_rob;
	logic [DISPATCH_WIDTH-1:0]        exp_stall;
	logic [DISPATCH_WIDTH-1:0]        exp_alloc;

	logic [31:0] lfsr;
	logic [31:0] pc_next;
	int          errors;
	int          checks;
	int          exhausted_seen;
	int          bypass_seen;
	int          allocations;
	int          guard;

	tb_clock clock_gen (.clock(clock));

	dispatch_top UUT (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.rs_stall(rs_stall),
		.rob_stall(rob_stall),
		.rob_index(rob_index),
		.complete_valid(complete_valid),
		.complete_pr(complete_pr),
		.retire_valid(retire_valid),
		.retire_pr(retire_pr),
		.rs_out(rs_out),
		.rob_out(rob_out),
		.stall(stall)
	);

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic alu_op_e alu_for(input logic [2:0] f3);
		case (f3)
			3'd0: return ALU_ADD;
			3'd1: return ALU_SLL;
			3'd2: return ALU_SLT;
			3'd3: return ALU_SLTU;
			3'd4: return ALU_XOR;
			3'd5: return ALU_SRL;
			3'd6: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// expected control fields straight from the RV32IM encoding rules
	function automatic decode_t decode_ref(input fetch_packet_t f);
		decode_t     d;
		logic [31:0] w;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic        ok;
		d = NOOP_DECODE;
		w = f.inst;
		f7 = w[31:25];
		f3 = w[14:12];
		ok = 1'b1;
		if (!f.valid)
			return d;
		case (w[6:0])
			OP_LUI, OP_AUIPC: begin
				d.dest = w[11:7];
				d.opa_select = (w[6:0] == OP_LUI) ? OPA_IS_ZERO : OPA_IS_PC;
				d.opb_select = OPB_IS_U_IMM;
			end
			OP_JAL: begin
				d.fu_sel = BRANCH;
				d.op_sel.br = UNCOND;
				d.dest = w[11:7];
				d.opa_select = OPA_IS_PC;
				d.opb_select = OPB_IS_J_IMM;
			end
			OP_JALR: begin
				d.fu_sel = BRANCH;
				d.op_sel.br = UNCOND;
				d.dest = w[11:7];
				d.rs1 = w[19:15];
				d.opb_select = OPB_IS_I_IMM;
				ok = (f3 == 3'b000);
			end
			OP_BRANCH: begin
				d.fu_sel = BRANCH;
				d.rs1 = w[19:15];
				d.rs2 = w[24:20];
				d.opa_select = OPA_IS_PC;
				d.opb_select = OPB_IS_B_IMM;
				case (f3)
					3'd0: d.op_sel.br = BEQ;
					3'd1: d.op_sel.br = BNE;
					3'd4: d.op_sel.br = BLT;
					3'd5: d.op_sel.br = BGE;
					3'd6: d.op_sel.br = BLTU;
					3'd7: d.op_sel.br = BGEU;
					default: ok = 1'b0;
				endcase
			end
			OP_LOAD: begin
				d.fu_sel = LS_1;
				d.dest = w[11:7];
				d.rs1 = w[19:15];
				d.opb_select = OPB_IS_I_IMM;
				case (f3)
					3'd0: d.op_sel.ls = LS_LB;
					3'd1: d.op_sel.ls = LS_LH;
					3'd2: d.op_sel.ls = LS_LW;
					3'd4: d.op_sel.ls = LS_LBU;
					3'd5: d.op_sel.ls = LS_LHU;
					default: ok = 1'b0;
				endcase
			end
			OP_STORE: begin
				d.fu_sel = LS_1;
				d.rs1 = w[19:15];
				d.rs2 = w[24:20];
				d.opb_select = OPB_IS_S_IMM;
				case (f3)
					3'd0: d.op_sel.ls = LS_SB;
					3'd1: d.op_sel.ls = LS_SH;
					3'd2: d.op_sel.ls = LS_SW;
					default: ok = 1'b0;
				endcase
			end
			OP_IMM: begin
				d.dest = w[11:7];
				d.rs1 = w[19:15];
				d.opb_select = OPB_IS_I_IMM;
				d.op_sel.alu = alu_for(f3);
				if (f3 == 3'd1)
					ok = (f7 == F7_BASE);
				if (f3 == 3'd5) begin
					if (f7 == F7_ALT)
						d.op_sel.alu = ALU_SRA;
					else
						ok = (f7 == F7_BASE);
				end
			end
			OP_REG: begin
				d.dest = w[11:7];
				d.rs1 = w[19:15];
				d.rs2 = w[24:20];
				if (f7 == F7_MULDIV) begin
					d.fu_sel = MULT_1;
					d.op_sel.mult = mult_op_e'({1'b0, f3});
					ok = !f3[2]; // divide unit not present
				end else if (f7 == F7_BASE)
					d.op_sel.alu = alu_for(f3);
				else if (f7 == F7_ALT && f3 == 3'd0)
					d.op_sel.alu = ALU_SUB;
				else if (f7 == F7_ALT && f3 == 3'd5)
					d.op_sel.alu = ALU_SRA;
				else
					ok = 1'b0;
			end
			OP_SYSTEM: begin
				if (w == WFI_INST)
					d.halt = 1'b1;
				else
					ok = 1'b0;
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			d = NOOP_DECODE;
			d.illegal = 1'b1;
		end
		return d;
	endfunction

	// expected outputs for the current inputs and model state
	function automatic void predict();
		pr_t     lmap [ARCH_REGS];
		logic    renamed [ARCH_REGS];
		decode_t d;
		logic    blocked;
		logic    wants;
		int      taken;
		blocked = 1'b0;
		taken = 0;
		for (int r = 0; r < ARCH_REGS; r++) begin
			lmap[r] = m_map[r];
			renamed[r] = 1'b0;
		end
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			d = decode_ref(fetch[i]);
			wants = fetch[i].valid && d.dest != ZERO_REG;
			if (rs_stall[i] || rob_stall[i])
				blocked = 1'b1;
			if (wants && taken >= free_q.size()) begin
				if (!blocked)
					exhausted_seen++;
				blocked = 1'b1;
			end
			exp_stall[i] = blocked;
			exp_alloc[i] = wants && !blocked;
			exp_rs[i] = '0;
			exp_rob[i] = '0;
			exp_rs[i].valid = fetch[i].valid && !blocked;
			exp_rs[i].dec = d;
			exp_rs[i].pc = fetch[i].pc;
			exp_rs[i].npc = fetch[i].npc;
			exp_rs[i].rob_entry = rob_index[i];
			exp_rs[i].rs1_pr = lmap[d.rs1];
			exp_rs[i].rs1_ready = renamed[d.rs1] ? 1'b0 : m_ready[lmap[d.rs1]];
			exp_rs[i].rs2_pr = lmap[d.rs2];
			exp_rs[i].rs2_ready = renamed[d.rs2] ? 1'b0 : m_ready[lmap[d.rs2]];
			if (exp_rs[i].valid && (renamed[d.rs1] || renamed[d.rs2]))
				bypass_seen++;
			exp_rob[i].valid = exp_rs[i].valid;
			exp_rob[i].dest_ar = d.dest;
			exp_rob[i].halt = d.halt;
			if (exp_alloc[i]) begin
				exp_rs[i].dest_pr = free_q[taken]; // k-th allocator, k-th free entry
				exp_rob[i].new_pr = free_q[taken];
				exp_rob[i].old_pr = lmap[d.dest];
				lmap[d.dest] = free_q[taken];
				renamed[d.dest] = 1'b1;
				taken++;
			end
		end
	endfunction

	// state change at the rising edge
	function automatic void advance_model();
		if (complete_valid) begin
			m_ready[complete_pr] = 1'b1;
			void'(busy_q.pop_front());
		end
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			if (exp_alloc[i]) begin
				m_map[exp_rob[i].dest_ar] = exp_rob[i].new_pr;
				m_ready[exp_rob[i].new_pr] = 1'b0; // rename beats completion
				busy_q.push_back(exp_rob[i].new_pr);
				rob_q.push_back(exp_rob[i].old_pr);
				void'(free_q.pop_front());
				allocations++;
			end
		end
		if (retire_valid) begin
			free_q.push_back(retire_pr);
			void'(rob_q.pop_front());
		end
	endfunction

	task automatic compare_value(input string name, input int slot,
			input logic [63:0] got, input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[FAIL] %s[%0d]: got %h, expected %h", name, slot, got, expected);
		end
	endtask

	task automatic compare_outputs();
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			compare_value("stall", i, 64'(stall[i]), 64'(exp_stall[i]));
			compare_value("rs_out.valid", i, 64'(rs_out[i].valid), 64'(exp_rs[i].valid));
			compare_value("rob_out.valid", i, 64'(rob_out[i].valid), 64'(exp_rob[i].valid));
			if (exp_rs[i].valid) begin
				compare_value("rs_out.dec", i, 64'(rs_out[i].dec), 64'(exp_rs[i].dec));
				compare_value("rs_out.pc", i, 64'(rs_out[i].pc), 64'(exp_rs[i].pc));
				compare_value("rs_out.npc", i, 64'(rs_out[i].npc), 64'(exp_rs[i].npc));
				compare_value("rs_out.rob_entry", i, 64'(rs_out[i].rob_entry),
					64'(exp_rs[i].rob_entry));
				compare_value("rs_out.rs1_pr", i, 64'(rs_out[i].rs1_pr), 64'(exp_rs[i].rs1_pr));
				compare_value("rs_out.rs1_ready", i, 64'(rs_out[i].rs1_ready),
					64'(exp_rs[i].rs1_ready));
				compare_value("rs_out.rs2_pr", i, 64'(rs_out[i].rs2_pr), 64'(exp_rs[i].rs2_pr));
				compare_value("rs_out.rs2_ready", i, 64'(rs_out[i].rs2_ready),
					64'(exp_rs[i].rs2_ready));
				compare_value("rob_out.dest_ar", i, 64'(rob_out[i].dest_ar),
					64'(exp_rob[i].dest_ar));
				compare_value("rob_out.halt", i, 64'(rob_out[i].halt), 64'(exp_rob[i].halt));
			end
			if (exp_alloc[i]) begin
				compare_value("rs_out.dest_pr", i, 64'(rs_out[i].dest_pr), 64'(exp_rs[i].dest_pr));
				compare_value("rob_out.new_pr", i, 64'(rob_out[i].new_pr),
					64'(exp_rob[i].new_pr));
				compare_value("rob_out.old_pr", i, 64'(rob_out[i].old_pr),
					64'(exp_rob[i].old_pr));
			end
		end
	endtask

	task automatic make_inst(output logic [31:0] w);
		logic [31:0] r;
		logic [31:0] u;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r = random_bits(32);
		u = random_bits(20);
		rd = {2'b00, r[2:0]}; // few registers so groups depend on each other
		rs1 = {2'b00, r[5:3]};
		rs2 = {2'b00, r[8:6]};
		f3 = r[11:9];
		case (r[13:12])
			2'd1: f7 = F7_ALT;
			2'd2: f7 = F7_MULDIV;
			default: f7 = F7_BASE;
		endcase
		case (r[17:14])
			4'd2, 4'd3: w = {f7, rs2, rs1, f3, rd, OP_IMM};
			4'd4: w = {u[11:0], rs1, f3, rd, OP_LOAD};
			4'd5: w = {u[6:0], rs2, rs1, f3, u[11:7], OP_STORE};
			4'd6: w = {u[6:0], rs2, rs1, f3, u[11:7], OP_BRANCH};
			4'd7: w = {u[19:0], rd, r[18] ? OP_LUI : OP_AUIPC};
			4'd8: w = {u[19:0], rd, OP_JAL};
			4'd9: w = {u[11:0], rs1, r[18] ? 3'b000 : f3, rd, OP_JALR};
			4'd10: w = WFI_INST;
			4'd11: w = {r[31:19], u[18:0]}; // raw word, mostly illegal
			4'd12: w = 32'h0000_0073; // ecall
			default: w = {f7, rs2, rs1, f3, rd, OP_REG};
		endcase
	endtask

	// stalled packets move to the front and are offered again
	task automatic drive_group(input logic fetch_on, input logic allow_retire);
		fetch_packet_t [DISPATCH_WIDTH-1:0] next;
		logic [31:0] r;
		logic [31:0] w;
		int          first;
		first = DISPATCH_WIDTH;
		for (int i = DISPATCH_WIDTH - 1; i >= 0; i--)
			if (exp_stall[i])
				first = i;
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			if (first + k < DISPATCH_WIDTH)
				next[k] = fetch[first + k];
			else begin
				r = random_bits(3);
				make_inst(w);
				next[k].valid = fetch_on && r[2:0] != 3'b000;
				next[k].inst = w;
				next[k].pc = pc_next;
				next[k].npc = pc_next + 32'd4;
				pc_next = pc_next + 32'd4;
			end
			if (!fetch_on)
				next[k].valid = 1'b0;
			r = random_bits(8);
			rs_stall[k] = fetch_on && r[3:0] == 4'h0;
			rob_stall[k] = fetch_on && r[7:4] == 4'h0;
		end
		fetch = next;
		r = random_bits(15);
		rob_index = r[14:0];
		r = random_bits(4);
		complete_valid = busy_q.size() > 0 && r[1:0] != 2'b00;
		complete_pr = complete_valid ? busy_q[0] : '0;
		retire_valid = allow_retire && rob_q.size() > 0 && r[3:2] != 2'b00;
		retire_pr = retire_valid ? rob_q[0] : '0;
	endtask

	// comparing process
	always begin
		@(negedge clock);
		#1;
		if (!reset) begin
			predict();
			compare_outputs();
			@(posedge clock);
			advance_model();
		end
	end

	initial begin
		lfsr = 32'h9d8a_8703;
		pc_next = 32'h0000_1000;
		errors = 0;
		checks = 0;
		exhausted_seen = 0;
		bypass_seen = 0;
		allocations = 0;
		reset = 1'b1;
		fetch = '0;
		rs_stall = '0;
		rob_stall = '0;
		rob_index = '0;
		complete_valid = 1'b0;
		complete_pr = '0;
		retire_valid = 1'b0;
		retire_pr = '0;
		exp_stall = '0;
		exp_alloc = '0;
		for (int r = 0; r < ARCH_REGS; r++)
			m_map[r] = pr_t'(r);
		for (int p = 0; p < PR_COUNT; p++)
			m_ready[p] = 1'b1;
		for (int p = ARCH_REGS; p < PR_COUNT; p++)
			free_q.push_back(pr_t'(p));

		repeat (16) @(negedge clock);
		reset = 1'b0;

		// addi x1 ; add x2, x1, x1 ; sw x2, 0(x1)
		fetch[0] = {1'b1, {12'd5, 5'd0, 3'b000, 5'd1, OP_IMM}, 32'h100, 32'h104};
		fetch[1] = {1'b1, {F7_BASE, 5'd1, 5'd1, 3'b000, 5'd2, OP_REG}, 32'h104, 32'h108};
		fetch[2] = {1'b1, {7'd0, 5'd2, 5'd1, 3'b010, 5'd0, OP_STORE}, 32'h108, 32'h10c};
		#1;
		compare_value("rob_out.new_pr", 0, 64'(rob_out[0].new_pr), 64'd32);
		compare_value("rob_out.new_pr", 1, 64'(rob_out[1].new_pr), 64'd33);
		compare_value("rs_out.rs1_pr", 1, 64'(rs_out[1].rs1_pr), 64'd32);
		compare_value("rs_out.rs1_ready", 1, 64'(rs_out[1].rs1_ready), 64'd0);
		compare_value("rs_out.rs2_pr", 2, 64'(rs_out[2].rs2_pr), 64'd33);

		// no retires at first, so the free list runs dry
		for (int cycle = 0; cycle < 300; cycle++) begin
			@(negedge clock);
			drive_group(1'b1, cycle >= 60);
		end

		guard = 0;
		while (rob_q.size() > 0 && guard < 400) begin
			@(negedge clock);
			drive_group(1'b0, 1'b1);
			guard++;
		end
		if (rob_q.size() > 0) begin
			errors++;
			$display("timeout: retire queue still held %0d entries after draining",
				rob_q.size());
		end

		for (int cycle = 0; cycle < 40; cycle++) begin
			@(negedge clock);
			drive_group(1'b1, 1'b1);
		end
		@(negedge clock);
		drive_group(1'b0, 1'b0);
		@(posedge clock);

		if (exhausted_seen == 0) begin
			errors++;
			$display("the free list never ran out during the run");
		end
		if (bypass_seen == 0) begin
			errors++;
			$display("no slot read a register renamed earlier in its group");
		end
		if (allocations <= PR_COUNT - ARCH_REGS) begin
			errors++;
			$display("no retired register was handed out again");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps
module tb_clock (
	output logic clock
);

	initial clock = 1'b0;

	always #2 clock = ~clock; // 4 ns period

endmodule
